//--- Bender.yml
package:
  name: prc

export_include_dirs:
  - include

sources:
  - files:
      - source/prc_bus_pkg.sv
      - source/prc_render_pkg.sv
      - source/prc_regs.sv
      - source/prc_frame_sequencer.sv
      - source/prc_map_renderer.sv
      - source/prc_frame_copier.sv
      - source/prc_bus_arbiter.sv
      - source/prc_top.sv
  - target: test
    files:
      - testbench/tb_prc.sv

//--- include/prc_macros.svh
`ifndef PRC_MACROS_SVH
`define PRC_MACROS_SVH

// CPU register addresses
`define PRC_REG_MODE        24'h002080
`define PRC_REG_RATE        24'h002081
`define PRC_REG_MAP_LO      24'h002082
`define PRC_REG_MAP_MID     24'h002083
`define PRC_REG_MAP_HI      24'h002084
`define PRC_REG_COUNTER     24'h00208A

// Memory map
`define PRC_TILEMAP_BASE    24'h001360
`define PRC_FB_BASE         24'h001000
`define PRC_LCD_CMD         24'h0020FE
`define PRC_LCD_DATA        24'h0020FF

// One line is PRC_OSC_LAST + 1 clocks
`define PRC_OSC_LAST        10'd854
`define PRC_LINE_START      7'h18
`define PRC_LINE_LAST       7'h42

// Screen geometry
`define PRC_COLS            96
`define PRC_TILES_PER_ROW   12

`endif

//--- source/prc_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module prc_bus_arbiter
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   map_req,
    input  prc_bus_pkg::bus_xact_t map_xact,
    output logic                   map_ack,
    input  logic                   copy_req,
    input  prc_bus_pkg::bus_xact_t copy_xact,
    output logic                   copy_ack,
    output prc_bus_pkg::data_t     rdata,
    output logic                   mem_req,
    output prc_bus_pkg::bus_xact_t mem_xact,
    input  logic                   mem_ack,
    input  prc_bus_pkg::data_t     mem_rdata
);

    logic granted;
    logic sel_copy;    // Low selects the map renderer
    logic mem_ack_q;

    assign mem_xact = sel_copy ? copy_xact : map_xact;
    assign mem_req  = granted && (sel_copy ? copy_req : map_req);
    assign map_ack  = granted && !sel_copy && mem_ack;
    assign copy_ack = granted && sel_copy && mem_ack;
    assign rdata    = mem_rdata;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            granted   <= 1'b0;
            sel_copy  <= 1'b0;
            mem_ack_q <= 1'b0;
        end
        else
        begin
            mem_ack_q <= mem_ack;
            if (!granted)
            begin
                if (!mem_req && !mem_ack && (map_req || copy_req))
                begin
                    granted  <= 1'b1;
                    sel_copy <= !map_req;   // Map wins a tie
                end
            end
            else if (mem_ack_q && !mem_ack)
                granted <= 1'b0;   // Transaction closed on the falling ack
        end
    end

    // Engines must hold their request until the grant is released
    assert property (@(posedge clk) disable iff (reset)
        mem_req && $past(mem_req) |-> $stable(mem_xact));

endmodule

`default_nettype wire

//--- source/prc_bus_pkg.sv
`default_nettype none

package prc_bus_pkg;

    typedef logic [23:0] addr_t;
    typedef logic [7:0]  data_t;

    typedef enum logic [1:0]
    {
        IDLE,
        MEM_READ,
        MEM_WRITE
    } bus_cmd_t;

    // One memory access that stays stable while req is high
    typedef struct packed
    {
        bus_cmd_t cmd;
        addr_t    addr;
        data_t    wdata;
    } bus_xact_t;

endpackage

`default_nettype wire

//--- source/prc_frame_copier.sv
`timescale 1ns/1ps
`default_nettype none
`include "prc_macros.svh"

module prc_frame_copier
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   copy_start,
    output logic                   req,
    output prc_bus_pkg::bus_xact_t xact,
    input  logic                   ack,
    input  prc_bus_pkg::data_t     rdata,
    output logic                   copy_done
);

    prc_render_pkg::copy_step_t step;
    prc_render_pkg::row_t       row;
    prc_render_pkg::col_t       col;
    prc_bus_pkg::data_t         fetched;
    prc_bus_pkg::bus_xact_t     next_xact;
    logic                       busy;
    logic                       last_col;

    assign last_col = (col == 7'(`PRC_COLS - 1));

    always_comb
    begin
        next_xact.cmd   = prc_bus_pkg::MEM_WRITE;
        next_xact.addr  = `PRC_LCD_CMD;
        next_xact.wdata = 8'h00;   // Column address low nibble
        case (step)
            prc_render_pkg::COLUMN_HI: next_xact.wdata = 8'h10;
            prc_render_pkg::PAGE_SET:  next_xact.wdata = {5'b10110, row};
            prc_render_pkg::FB_READ:
            begin
                next_xact.cmd  = prc_bus_pkg::MEM_READ;
                next_xact.addr = prc_bus_pkg::addr_t'(`PRC_FB_BASE + row * `PRC_COLS + col);
            end
            prc_render_pkg::LCD_WRITE:
            begin
                next_xact.addr  = `PRC_LCD_DATA;
                next_xact.wdata = fetched;
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            req       <= 1'b0;
            copy_done <= 1'b0;
            step      <= prc_render_pkg::COLUMN_HI;
            row       <= '0;
            col       <= '0;
        end
        else
        begin
            copy_done <= 1'b0;
            if (copy_start && !busy)
            begin
                busy <= 1'b1;
                step <= prc_render_pkg::COLUMN_HI;
                row  <= '0;
                col  <= '0;
            end
            else if (busy && !req && !ack)
                req <= 1'b1;
            else if (req && ack)
            begin
                req <= 1'b0;
                case (step)
                    prc_render_pkg::COLUMN_HI: step <= prc_render_pkg::COLUMN_LO;
                    prc_render_pkg::COLUMN_LO: step <= prc_render_pkg::PAGE_SET;
                    prc_render_pkg::PAGE_SET:  step <= prc_render_pkg::FB_READ;
                    prc_render_pkg::FB_READ:   step <= prc_render_pkg::LCD_WRITE;
                    default:
                    begin
                        // End of a page goes back to the LCD commands
                        step <= last_col ? prc_render_pkg::COLUMN_HI : prc_render_pkg::FB_READ;
                        col  <= last_col ? 7'd0 : col + 7'd1;
                        if (last_col)
                            row <= row + 3'd1;
                        if (last_col && row == 3'd7)
                        begin
                            busy      <= 1'b0;
                            copy_done <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (busy && !req && !ack)
            xact <= next_xact;
        if (req && ack && step == prc_render_pkg::FB_READ)
            fetched <= rdata;
    end

endmodule

`default_nettype wire

//--- source/prc_frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "prc_macros.svh"

module prc_frame_sequencer
(
    input  logic                     clk,
    input  logic                     reset,
    input  prc_render_pkg::prc_cfg_t cfg,
    input  logic                     rate_changed,
    input  logic                     map_done,
    input  logic                     copy_done,
    output logic                     map_start,
    output logic                     copy_start,
    output logic                     irq_render_done,
    output logic [3:0]               frame_skip,
    output prc_render_pkg::line_t    line
);

    logic [9:0] osc;
    logic [3:0] rate_match;
    logic       tick;
    logic       frame_active;
    logic       stage_start;
    logic       map_busy;
    logic       copy_busy;

    assign tick         = (osc == `PRC_OSC_LAST);
    assign frame_active = (frame_skip == rate_match);
    assign stage_start  = tick && frame_active && (line == `PRC_LINE_START - 7'd1);

    always_comb
    begin
        case (cfg.rate_div)
            3'd0:    rate_match = 4'h2;   // Every 3rd frame
            3'd1:    rate_match = 4'h5;
            3'd2:    rate_match = 4'h8;
            3'd3:    rate_match = 4'hB;
            3'd4:    rate_match = 4'h1;   // Every 2nd frame
            3'd5:    rate_match = 4'h3;
            3'd6:    rate_match = 4'h5;
            default: rate_match = 4'h7;
        endcase
    end

    // Frame pacing runs free and never waits on the engines
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            osc             <= '0;
            line            <= 7'd1;
            frame_skip      <= 4'h0;
            irq_render_done <= 1'b0;
        end
        else
        begin
            irq_render_done <= 1'b0;
            osc             <= osc + 10'd1;
            if (tick)
            begin
                osc <= '0;
                if (line == `PRC_LINE_LAST)
                begin
                    line <= 7'd1;
                    if (frame_active)
                    begin
                        frame_skip      <= 4'h0;
                        irq_render_done <= 1'b1;
                    end
                    else
                        frame_skip <= frame_skip + 4'h1;
                end
                else
                    line <= line + 7'd1;
            end
            if (rate_changed)
                frame_skip <= 4'h0;   // New divider restarts the count
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            map_start  <= 1'b0;
            copy_start <= 1'b0;
            map_busy   <= 1'b0;
            copy_busy  <= 1'b0;
        end
        else
        begin
            map_start  <= 1'b0;
            copy_start <= 1'b0;
            if (map_done)
                map_busy <= 1'b0;
            if (copy_done)
                copy_busy <= 1'b0;

            if (stage_start && cfg.map_en && !map_busy)
            begin
                map_start <= 1'b1;
                map_busy  <= 1'b1;
            end
            else if (stage_start && !cfg.map_en && cfg.copy_en && !copy_busy)
            begin
                copy_start <= 1'b1;
                copy_busy  <= 1'b1;
            end

            // Copy follows the map render
            if (map_done && cfg.copy_en && !copy_busy)
            begin
                copy_start <= 1'b1;
                copy_busy  <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(map_start && copy_start));

endmodule

`default_nettype wire

//--- source/prc_map_renderer.sv
`timescale 1ns/1ps
`default_nettype none
`include "prc_macros.svh"

module prc_map_renderer
(
    input  logic                     clk,
    input  logic                     reset,
    input  prc_render_pkg::prc_cfg_t cfg,
    input  logic                     map_start,
    output logic                     req,
    output prc_bus_pkg::bus_xact_t   xact,
    input  logic                     ack,
    input  prc_bus_pkg::data_t       rdata,
    output logic                     map_done
);

    prc_render_pkg::map_step_t step;
    prc_render_pkg::row_t      row;
    prc_render_pkg::col_t      col;
    prc_bus_pkg::data_t        fetched;   // Tile index, then tile byte
    prc_bus_pkg::bus_xact_t    next_xact;
    logic                      busy;
    logic                      last_col;

    assign last_col = (col == 7'(`PRC_COLS - 1));

    always_comb
    begin
        next_xact.cmd   = prc_bus_pkg::MEM_READ;
        next_xact.wdata = fetched;
        case (step)
            prc_render_pkg::TILE_INDEX:
                next_xact.addr = prc_bus_pkg::addr_t'(`PRC_TILEMAP_BASE
                                 + row * `PRC_TILES_PER_ROW + col[6:3]);
            prc_render_pkg::TILE_DATA:
                next_xact.addr = prc_bus_pkg::addr_t'(cfg.map_base
                                 + {fetched, 3'b000} + col[2:0]);
            default:
            begin
                next_xact.cmd  = prc_bus_pkg::MEM_WRITE;
                next_xact.addr = prc_bus_pkg::addr_t'(`PRC_FB_BASE + row * `PRC_COLS + col);
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            req      <= 1'b0;
            map_done <= 1'b0;
            step     <= prc_render_pkg::TILE_INDEX;
            row      <= '0;
            col      <= '0;
        end
        else
        begin
            map_done <= 1'b0;
            if (map_start && !busy)
            begin
                busy <= 1'b1;
                step <= prc_render_pkg::TILE_INDEX;
                row  <= '0;
                col  <= '0;
            end
            else if (busy && !req && !ack)
                req <= 1'b1;   // Previous access fully closed
            else if (req && ack)
            begin
                req <= 1'b0;
                case (step)
                    prc_render_pkg::TILE_INDEX: step <= prc_render_pkg::TILE_DATA;
                    prc_render_pkg::TILE_DATA:  step <= prc_render_pkg::FB_WRITE;
                    default:
                    begin
                        step <= prc_render_pkg::TILE_INDEX;
                        col  <= last_col ? 7'd0 : col + 7'd1;
                        if (last_col)
                            row <= row + 3'd1;
                        if (last_col && row == 3'd7)
                        begin
                            busy     <= 1'b0;
                            map_done <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (busy && !req && !ack)
            xact <= next_xact;
        if (req && ack && step != prc_render_pkg::FB_WRITE)
            fetched <= rdata;
    end

endmodule

`default_nettype wire

//--- source/prc_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "prc_macros.svh"

module prc_regs
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     reg_write,
    input  prc_bus_pkg::addr_t       reg_addr,
    input  prc_bus_pkg::data_t       reg_wdata,
    output prc_bus_pkg::data_t       reg_rdata,
    input  logic [3:0]               frame_skip,
    input  prc_render_pkg::line_t    line,
    output prc_render_pkg::prc_cfg_t cfg,
    output logic                     rate_changed
);

    logic               map_en;
    logic               copy_en;
    logic [3:0]         rate_low;   // Bits 3:1 pick the divider
    prc_bus_pkg::addr_t map_base;

    assign rate_changed = reg_write && (reg_addr == `PRC_REG_RATE)
                          && (reg_wdata[3:1] != rate_low[3:1]);

    assign cfg = '{map_en: map_en, copy_en: copy_en, rate_div: rate_low[3:1],
                   map_base: map_base};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            map_en   <= 1'b0;
            copy_en  <= 1'b0;
            rate_low <= 4'h0;
            map_base <= '0;
        end
        else if (reg_write)
        begin
            case (reg_addr)
                `PRC_REG_MODE:
                begin
                    map_en  <= reg_wdata[1];
                    copy_en <= reg_wdata[3];
                end
                `PRC_REG_RATE:    rate_low <= reg_wdata[3:0];
                `PRC_REG_MAP_LO:  map_base[7:3] <= reg_wdata[7:3];   // Tile base is 8-byte aligned
                `PRC_REG_MAP_MID: map_base[15:8] <= reg_wdata;
                `PRC_REG_MAP_HI:  map_base[20:16] <= reg_wdata[4:0];
                default:
                begin
                end
            endcase
        end
    end

    always_comb
    begin
        case (reg_addr)
            `PRC_REG_MODE:    reg_rdata = {4'h0, copy_en, 1'b0, map_en, 1'b0};
            `PRC_REG_RATE:    reg_rdata = {frame_skip, rate_low};
            `PRC_REG_MAP_LO:  reg_rdata = {map_base[7:3], 3'b000};
            `PRC_REG_MAP_MID: reg_rdata = map_base[15:8];
            `PRC_REG_MAP_HI:  reg_rdata = {3'b000, map_base[20:16]};
            `PRC_REG_COUNTER: reg_rdata = {1'b0, line};
            default:          reg_rdata = '0;
        endcase
    end

    // A skip counter clear comes from a CPU write that really moves the divider
    assert property (@(posedge clk) disable iff (reset)
        rate_changed |-> reg_write ##1 (cfg.rate_div != $past(cfg.rate_div)));

endmodule

`default_nettype wire

//--- source/prc_render_pkg.sv
`default_nettype none

package prc_render_pkg;

    typedef logic [6:0] col_t;
    typedef logic [2:0] row_t;   // LCD page
    typedef logic [6:0] line_t;

    typedef enum logic [1:0]
    {
        TILE_INDEX,
        TILE_DATA,
        FB_WRITE
    } map_step_t;

    typedef enum logic [2:0]
    {
        COLUMN_HI,
        COLUMN_LO,
        PAGE_SET,
        FB_READ,
        LCD_WRITE
    } copy_step_t;

    typedef struct packed
    {
        logic               map_en;
        logic               copy_en;
        logic [2:0]         rate_div;
        prc_bus_pkg::addr_t map_base;
    } prc_cfg_t;

endpackage

`default_nettype wire

//--- source/prc_top.sv
`timescale 1ns/1ps
`default_nettype none

module prc_top
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   reg_write,
    input  prc_bus_pkg::addr_t     reg_addr,
    input  prc_bus_pkg::data_t     reg_wdata,
    output prc_bus_pkg::data_t     reg_rdata,
    output logic                   mem_req,
    output prc_bus_pkg::bus_xact_t mem_xact,
    input  logic                   mem_ack,
    input  prc_bus_pkg::data_t     mem_rdata,
    output logic                   irq_render_done,
    output logic                   irq_copy_complete
);

    prc_render_pkg::prc_cfg_t cfg;
    prc_render_pkg::line_t    line;
    logic [3:0]               frame_skip;
    logic                     rate_changed;
    logic                     map_start;
    logic                     map_done;
    logic                     copy_start;
    logic                     copy_done;
    logic                     map_req;
    logic                     map_ack;
    logic                     copy_req;
    logic                     copy_ack;
    prc_bus_pkg::bus_xact_t   map_xact;
    prc_bus_pkg::bus_xact_t   copy_xact;
    prc_bus_pkg::data_t       bus_rdata;   // Read data shared by both engines

    assign irq_copy_complete = copy_done;

    prc_regs u_regs (.*);

    prc_frame_sequencer u_sequencer (.*);

    prc_map_renderer u_map
    (
        .*,
        .req   (map_req),
        .xact  (map_xact),
        .ack   (map_ack),
        .rdata (bus_rdata)
    );

    prc_frame_copier u_copy
    (
        .*,
        .req   (copy_req),
        .xact  (copy_xact),
        .ack   (copy_ack),
        .rdata (bus_rdata)
    );

    prc_bus_arbiter u_arbiter
    (
        .*,
        .rdata (bus_rdata)
    );

endmodule

`default_nettype wire

//--- src.f
+incdir+include
source/prc_bus_pkg.sv
source/prc_render_pkg.sv
source/prc_regs.sv
source/prc_frame_sequencer.sv
source/prc_map_renderer.sv
source/prc_frame_copier.sv
source/prc_bus_arbiter.sv
source/prc_top.sv
testbench/tb_prc.sv

//--- testbench/tb_prc.sv
`timescale 1ns/1ps
`default_nettype none
`include "prc_macros.svh"

module tb_prc;

    localparam int          CLK_PERIOD      = 10;
    localparam int          FB_BYTES        = 8 * `PRC_COLS;
    localparam int          LINE_CYCLES     = `PRC_OSC_LAST + 1;
    localparam int          FRAME_CYCLES    = `PRC_LINE_LAST * LINE_CYCLES;   // Lines 1 to 0x42
    localparam int          TEST_FRAMES     = 1 + 6 + 4 + 4 + 3;   // Worst case of each test
    localparam longint      WATCHDOG_CYCLES = longint'(TEST_FRAMES + 2) * FRAME_CYCLES;
    localparam logic [31:0] SEED            = 32'h0a72c22c;
    localparam prc_bus_pkg::addr_t MAP_BASE = 24'h004000;

    logic                   clk;
    logic                   reset;
    logic                   reg_write;
    prc_bus_pkg::addr_t     reg_addr;
    prc_bus_pkg::data_t     reg_wdata;
    prc_bus_pkg::data_t     reg_rdata;
    logic                   mem_req;
    prc_bus_pkg::bus_xact_t mem_xact;
    logic                   mem_ack = 1'b0;
    prc_bus_pkg::data_t     mem_rdata = '0;
    logic                   irq_render_done;
    logic                   irq_copy_complete;

    prc_bus_pkg::data_t     mem [0:65535];
    prc_bus_pkg::data_t     exp_fb [0:FB_BYTES-1];
    logic [8:0]             lcd_log [$];   // Bit 8 set for the data register
    logic [31:0]            rng_state = SEED;
    logic [1:0]             delay = 2'd0;
    int                     mismatches = 0;
    int                     failures = 0;
    int                     render_irqs = 0;
    int                     copy_irqs = 0;
    int                     fb_writes = 0;
    longint                 cycle = 0;
    longint                 last_render_cycle = 0;
    longint                 first_req_cycle = 0;
    logic                   req_seen = 1'b1;
    logic                   order_check = 1'b0;
    logic                   render_prev = 1'b0;
    logic                   copy_prev = 1'b0;
    prc_bus_pkg::addr_t     last_fb_addr = '0;

    prc_top u_prc_top
    (
        .clk               (clk),
        .reset             (reset),
        .reg_write         (reg_write),
        .reg_addr          (reg_addr),
        .reg_wdata         (reg_wdata),
        .reg_rdata         (reg_rdata),
        .mem_req           (mem_req),
        .mem_xact          (mem_xact),
        .mem_ack           (mem_ack),
        .mem_rdata         (mem_rdata),
        .irq_render_done   (irq_render_done),
        .irq_copy_complete (irq_copy_complete)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Tile byte that a pixel should get from the model memory
    function automatic prc_bus_pkg::data_t predict_tile(input prc_render_pkg::row_t r,
                                                        input prc_render_pkg::col_t c);
        prc_bus_pkg::data_t index;
        index = mem[`PRC_TILEMAP_BASE + r * `PRC_TILES_PER_ROW + c / 8];
        return mem[MAP_BASE + index * 8 + c % 8];
    endfunction

    // Four-phase memory and LCD model
    always @(posedge clk)
    begin
        if (reset)
        begin
            mem_ack <= 1'b0;
            delay   <= 2'd0;
        end
        else if (mem_ack && !mem_req)
        begin
            mem_ack   <= 1'b0;
            rng_state = xorshift32(rng_state);
            delay     <= rng_state[1:0];
        end
        else if (!mem_ack && mem_req && delay != 2'd0)
            delay <= delay - 2'd1;
        else if (!mem_ack && mem_req)
        begin
            mem_ack <= 1'b1;
            if (mem_xact.cmd == prc_bus_pkg::MEM_READ)
                mem_rdata <= mem[mem_xact.addr[15:0]];
            else if (mem_xact.addr == `PRC_LCD_CMD || mem_xact.addr == `PRC_LCD_DATA)
            begin
                if (order_check && fb_writes < FB_BYTES)
                begin
                    $display("LCD write after only %0d of %0d framebuffer writes",
                             fb_writes, FB_BYTES);
                    failures++;
                end
                lcd_log.push_back({mem_xact.addr == `PRC_LCD_DATA, mem_xact.wdata});
            end
            else
            begin
                mem[mem_xact.addr[15:0]] = mem_xact.wdata;
                if (mem_xact.addr >= `PRC_FB_BASE && mem_xact.addr < `PRC_FB_BASE + FB_BYTES)
                begin
                    fb_writes++;
                    last_fb_addr = mem_xact.addr;
                end
            end
        end
    end

    // Cycle count, irq counts and pulse width
    always @(posedge clk)
    begin
        cycle       <= cycle + 1;
        render_prev <= irq_render_done;
        copy_prev   <= irq_copy_complete;
        if (irq_render_done)
        begin
            render_irqs       <= render_irqs + 1;
            last_render_cycle <= cycle;
        end
        if (irq_copy_complete)
            copy_irqs <= copy_irqs + 1;
        if ((irq_render_done && render_prev) || (irq_copy_complete && copy_prev))
        begin
            $display("An irq stayed high for more than one cycle at cycle %0d", cycle);
            failures++;
        end
        if (mem_req && !req_seen)
        begin
            req_seen        = 1'b1;
            first_req_cycle = cycle;
        end
    end

    task automatic compare_data(input string name, input prc_bus_pkg::data_t got,
                                input prc_bus_pkg::data_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_addr(input string name, input prc_bus_pkg::addr_t got,
                                input prc_bus_pkg::addr_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_cycles(input string name, input longint got, input longint exp);
        if (got != exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic write_reg(input prc_bus_pkg::addr_t a, input prc_bus_pkg::data_t d);
        @(posedge clk);
        reg_write <= 1'b1;
        reg_addr  <= a;
        reg_wdata <= d;
        @(posedge clk);
        reg_write <= 1'b0;
    endtask

    task automatic read_reg(input prc_bus_pkg::addr_t a, output prc_bus_pkg::data_t d);
        @(posedge clk);
        reg_addr <= a;
        @(negedge clk);
        d = reg_rdata;
    endtask

    task automatic wait_irq(input logic copy, input int target, input int frames);
        longint limit;
        limit = cycle + longint'(frames) * FRAME_CYCLES;
        while ((copy ? copy_irqs : render_irqs) < target && cycle < limit)
            @(posedge clk);
        if ((copy ? copy_irqs : render_irqs) < target)
        begin
            $display("%s did not pulse within %0d frames",
                     copy ? "irq_copy_complete" : "irq_render_done", frames);
            failures++;
        end
    endtask

    // Per page three commands, then the page's bytes in column order
    task automatic check_lcd_log;
        int                 k;
        int                 r;
        int                 j;
        logic [8:0]         entry;
        prc_bus_pkg::data_t exp_byte;
        k = 0;
        if (lcd_log.size() != 8 * (3 + `PRC_COLS))
        begin
            $display("LCD log holds %0d writes instead of %0d", lcd_log.size(),
                     8 * (3 + `PRC_COLS));
            failures++;
            return;
        end
        for (r = 0; r < 8; r++)
        begin
            for (j = 0; j < 3 + `PRC_COLS; j++)
            begin
                case (j)
                    0:       exp_byte = 8'h10;
                    1:       exp_byte = 8'h00;
                    2:       exp_byte = 8'hB0 + 8'(r);
                    default: exp_byte = exp_fb[r * `PRC_COLS + j - 3];
                endcase
                entry = lcd_log[k];
                if (entry[8] != (j >= 3))
                begin
                    $display("LCD write %0d went to the wrong LCD register", k);
                    failures++;
                end
                compare_data($sformatf("lcd_byte[%0d]", k), entry[7:0], exp_byte);
                k++;
            end
        end
    endtask

    task automatic register_access;
        prc_bus_pkg::data_t lo;
        prc_bus_pkg::data_t mid;
        prc_bus_pkg::data_t hi;
        prc_bus_pkg::data_t d;
        read_reg(`PRC_REG_COUNTER, d);
        compare_data("reg_counter after reset", d, 8'h01);
        write_reg(`PRC_REG_MODE, 8'hFF);
        read_reg(`PRC_REG_MODE, d);
        compare_data("reg_mode", d, 8'h0A);   // Only bits 1 and 3 are kept
        write_reg(`PRC_REG_MODE, 8'h00);
        read_reg(`PRC_REG_MODE, d);
        compare_data("reg_mode cleared", d, 8'h00);
        write_reg(`PRC_REG_MAP_LO, 8'hFF);
        write_reg(`PRC_REG_MAP_MID, 8'hA5);
        write_reg(`PRC_REG_MAP_HI, 8'hFF);
        read_reg(`PRC_REG_MAP_LO, lo);
        read_reg(`PRC_REG_MAP_MID, mid);
        read_reg(`PRC_REG_MAP_HI, hi);
        compare_addr("map_base readback", {hi, mid, lo}, 24'h1FA5F8);
        read_reg(24'h002085, d);
        compare_data("unmapped 0x002085", d, 8'h00);
        // Frame 0 at divider 0 is inactive so the skip count reads 1 after it
        repeat (FRAME_CYCLES) @(posedge clk);
        read_reg(`PRC_REG_RATE, d);
        compare_data("reg_rate skip count", d, 8'h10);
        write_reg(`PRC_REG_RATE, 8'h08);
        read_reg(`PRC_REG_RATE, d);
        compare_data("reg_rate after new divider", d, 8'h08);
    endtask

    task automatic frame_pacing;
        longint             first;
        int                 n;
        int                 i;
        prc_bus_pkg::data_t d;
        write_reg(`PRC_REG_RATE, 8'h00);   // Every third frame
        wait_irq(1'b0, render_irqs + 1, 4);
        first = last_render_cycle;
        n = render_irqs;
        for (i = 0; i < 5; i++)
        begin
            repeat (FRAME_CYCLES / 2) @(posedge clk);
            read_reg(`PRC_REG_COUNTER, d);
            if (d < 8'h01 || d > `PRC_LINE_LAST)
            begin
                $display("MISMATCH reg_counter: got 0x%h, expected 0x01 to 0x%h",
                         d, `PRC_LINE_LAST);
                mismatches++;
            end
        end
        wait_irq(1'b0, n + 1, 2);
        compare_cycles("irq_render_done spacing", last_render_cycle - first, 3 * FRAME_CYCLES);
    endtask

    task automatic map_render;
        longint sync;
        int     n;
        int     copies;
        int     i;
        write_reg(`PRC_REG_MAP_LO, MAP_BASE[7:0]);
        write_reg(`PRC_REG_MAP_MID, MAP_BASE[15:8]);
        write_reg(`PRC_REG_MAP_HI, {3'b000, MAP_BASE[20:16]});
        write_reg(`PRC_REG_RATE, 8'h08);   // Every second frame
        write_reg(`PRC_REG_MODE, 8'h02);
        wait_irq(1'b0, render_irqs + 1, 3);
        sync = last_render_cycle;
        n = render_irqs;
        copies = copy_irqs;
        for (i = 0; i < FB_BYTES; i++)
            mem[`PRC_FB_BASE + i] = ~predict_tile(i / `PRC_COLS, i % `PRC_COLS);
        req_seen = 1'b0;
        wait_irq(1'b0, n + 1, 3);
        if (!req_seen || first_req_cycle - sync < FRAME_CYCLES
            + (`PRC_LINE_START - 1) * LINE_CYCLES)
        begin
            $display("Map render used the bus before line 0x%h", `PRC_LINE_START);
            failures++;
        end
        for (i = 0; i < FB_BYTES; i++)
            compare_data($sformatf("fb[%0d]", i), mem[`PRC_FB_BASE + i],
                         predict_tile(i / `PRC_COLS, i % `PRC_COLS));
        compare_addr("last framebuffer write", last_fb_addr, `PRC_FB_BASE + FB_BYTES - 1);
        compare_cycles("irq_copy_complete pulses", copy_irqs - copies, 0);
    endtask

    task automatic frame_copy;
        int n;
        int copies;
        int i;
        write_reg(`PRC_REG_MODE, 8'h08);
        for (i = 0; i < FB_BYTES; i++)
        begin
            exp_fb[i] = i[7:0] ^ {6'b000000, i[9:8]} ^ 8'hC3;
            mem[`PRC_FB_BASE + i] = exp_fb[i];
        end
        lcd_log.delete();
        wait_irq(1'b1, copy_irqs + 1, 3);
        check_lcd_log();
        n = render_irqs;
        wait_irq(1'b0, n + 1, 2);   // End of the copy's own frame
        copies = copy_irqs;
        wait_irq(1'b0, n + 2, 3);
        compare_cycles("irq_copy_complete per active frame", copy_irqs - copies, 1);
    endtask

    task automatic render_then_copy;
        int i;
        write_reg(`PRC_REG_MODE, 8'h0A);
        for (i = 0; i < FB_BYTES; i++)
        begin
            exp_fb[i] = predict_tile(i / `PRC_COLS, i % `PRC_COLS);
            mem[`PRC_FB_BASE + i] = ~exp_fb[i];
        end
        lcd_log.delete();
        fb_writes   = 0;
        order_check = 1'b1;
        wait_irq(1'b1, copy_irqs + 1, 3);
        order_check = 1'b0;
        for (i = 0; i < FB_BYTES; i++)
            compare_data($sformatf("fb[%0d]", i), mem[`PRC_FB_BASE + i], exp_fb[i]);
        check_lcd_log();
    endtask

    initial
    begin
        int a;
        reset     = 1'b1;
        reg_write = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        for (a = 0; a < 65536; a++)
        begin
            rng_state = xorshift32(rng_state);
            mem[a]    = rng_state[7:0];
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        register_access();
        frame_pacing();
        map_render();
        frame_copy();
        render_then_copy();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
